// ==== filelist.f ====
+incdir+.
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
cpu.sv
tb_cpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_cpu -f filelist.f -o tb_cpu_sim

# exit status of the simulation is the verdict
./obj_dir/tb_cpu_sim

// ==== tb_cpu_model.svh ====
// architectural model and random program generator for programs of at most 128 words whose beq reads only x1..x4
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

localparam int DUMP_BASE     = 96; // doubleword slot that receives x1
localparam int SCRATCH_SLOTS = 16; // doubleword slots 0..15 for body loads and stores

logic [31:0] lcg_state = 32'h780a;
logic [31:0] prog [0:`IMEM_DEPTH-1];
int          prog_len;
logic [63:0] m_regs [0:31];
logic [63:0] m_mem [0:`DMEM_DEPTH-1];

function automatic int rand_below(input int n);
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return int'(lcg_state[31:8]) % n; // low lcg bits are weak
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input int rd, input int rs1, input int rs2);
   return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                      input int rd, input int rs1, input logic [11:0] imm);
   return {imm, 5'(rs1), f3, 5'(rd), op};
endfunction

// sd rs2, imm(x0)
function automatic logic [31:0] enc_s(input int rs2, input logic [11:0] imm);
   return {imm[11:5], 5'(rs2), 5'd0, 3'd3, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(input int rs1, input int rs2, input logic [12:0] off);
   return {off[12], off[10:5], 5'(rs2), 5'(rs1), 3'd0, off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] enc_j(input int rd, input logic [20:0] off);
   return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'h6f};
endfunction

// prologue sets x1..x31 then a random body and an epilogue that dumps x1..x31 and jumps to itself
function automatic void gen_program();
   int                       idx;
   int                       body_end;
   int                       shadow_end;
   int                       last_rd;
   int                       rd;
   int                       rs1;
   int                       rs2;
   int                       k;
   int                       skip;
   int                       kind;
   logic [11:0]              x1_imm;
   logic [SCRATCH_SLOTS-1:0] stored;
   idx        = 0;
   shadow_end = 0;
   last_rd    = 5;
   stored     = '0;
   x1_imm     = 12'(rand_below(4096));
   for (rd = 1; rd < 32; rd++) begin
      prog[idx] = enc_i(7'h13, 3'd0, rd, 0, (rd <= 2) ? x1_imm : 12'(rand_below(4096)));
      idx++; // x1 and x2 share a value so some beq are taken
   end
   body_end = idx + 24 + rand_below(33);
   while (idx < body_end) begin
      rd   = 5 + rand_below(27); // x1..x4 stay fixed for beq
      rs1  = (rand_below(2) == 0) ? last_rd : 1 + rand_below(31);
      rs2  = 1 + rand_below(31);
      skip = 1 + rand_below(3);
      kind = rand_below(10);
      if (kind == 7 && stored == '0)
         kind = 4;
      if (kind >= 8 && idx + skip >= body_end)
         kind = 4; // target must stay inside the body
      case (kind)
         0, 1, 2, 3: begin
            case (rand_below(5))
               0:       prog[idx] = enc_r(7'h00, 3'd0, rd, rs1, rs2);
               1:       prog[idx] = enc_r(7'h20, 3'd0, rd, rs1, rs2); // sub
               2:       prog[idx] = enc_r(7'h00, 3'd7, rd, rs1, rs2);
               3:       prog[idx] = enc_r(7'h00, 3'd6, rd, rs1, rs2);
               default: prog[idx] = enc_r(7'h00, 3'd2, rd, rs1, rs2); // slt
            endcase
            last_rd = rd;
         end
         6: begin
            k         = rand_below(SCRATCH_SLOTS);
            prog[idx] = enc_s(rs1, 12'(8 * k));
            if (idx >= shadow_end)
               stored[k] = 1'b1; // never skipped so safe to load later
         end
         7: begin
            do
               k = rand_below(SCRATCH_SLOTS);
            while (!stored[k]);
            prog[idx] = enc_i(7'h03, 3'd3, rd, 0, 12'(8 * k));
            last_rd   = rd; // next instr likely uses it
         end
         8, 9: begin
            if (kind == 8) begin
               prog[idx] = enc_b(1 + rand_below(4), 1 + rand_below(4), 13'((skip + 1) * 4));
            end else begin
               prog[idx] = enc_j(rd, 21'((skip + 1) * 4));
               last_rd   = rd;
            end
            if (idx + skip + 1 > shadow_end)
               shadow_end = idx + skip + 1;
         end
         default: begin
            prog[idx] = enc_i(7'h13, 3'd0, rd, rs1, 12'(rand_below(4096)));
            last_rd   = rd;
         end
      endcase
      idx++;
   end
   for (rd = 1; rd < 32; rd++) begin
      prog[idx] = enc_s(rd, 12'(8 * (DUMP_BASE + rd - 1)));
      idx++;
   end
   prog[idx] = enc_j(0, 21'd0);
   prog_len  = idx + 1;
endfunction

// steps one instruction at a time and returns 1 at the final self jump
function automatic bit run_model();
   logic [63:0] pc;
   logic [63:0] next_pc;
   logic [63:0] a;
   logic [63:0] b;
   logic [63:0] res;
   logic [63:0] addr;
   logic [63:0] imm_i;
   logic [63:0] imm_s;
   logic [63:0] imm_b;
   logic [63:0] imm_j;
   logic [31:0] ins;
   bit          wr;
   int          step;
   pc        = '0;
   m_regs[0] = '0;
   for (step = 0; step < 4 * `IMEM_DEPTH; step++) begin
      ins     = prog[pc[8:2]];
      a       = m_regs[ins[19:15]];
      b       = m_regs[ins[24:20]];
      imm_i   = {{52{ins[31]}}, ins[31:20]};
      imm_s   = {{52{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b   = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j   = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      next_pc = pc + 64'd4;
      res     = '0;
      wr      = 1'b0;
      case (ins[6:0])
         7'h33: begin
            wr = 1'b1;
            case ({ins[30], ins[14:12]})
               4'b0000: res = a + b;
               4'b1000: res = a - b;
               4'b0111: res = a & b;
               4'b0110: res = a | b;
               4'b0010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
               default: wr = 1'b0;
            endcase
         end
         7'h13: begin
            res = a + imm_i;
            wr  = 1'b1;
         end
         7'h03: begin
            addr = a + imm_i;
            res  = m_mem[addr[9:3]];
            wr   = 1'b1;
         end
         7'h23: begin
            addr             = a + imm_s;
            m_mem[addr[9:3]] = b;
         end
         7'h63: begin
            if (a == b)
               next_pc = pc + imm_b;
         end
         7'h6f: begin
            if (imm_j == '0)
               return 1'b1;
            res     = pc + 64'd4; // link
            wr      = 1'b1;
            next_pc = pc + imm_j;
         end
         default: ;
      endcase
      if (wr && ins[11:7] != 5'd0)
         m_regs[ins[11:7]] = res;
      pc = next_pc;
   end
   return 1'b0;
endfunction

`endif

// ==== tb_cpu.sv ====
// random programs run with enable toggled; results are read back from the dump area of data memory
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpu;

   localparam int NUM_PROGRAMS    = 8;
   // worst case per program covers load, reset, run with frozen spans and dump
   localparam int WATCHDOG_CYCLES = NUM_PROGRAMS * (`IMEM_DEPTH * 5 + 160) + 20;

   logic             clk;
   logic             reset;
   logic             enable;
   logic [`XLEN-1:0] imem_addr;
   logic             imem_wen;
   logic [`ILEN-1:0] imem_wdata;
   logic [`XLEN-1:0] dmem_addr;
   logic             dmem_ren;
   logic [`XLEN-1:0] dmem_rdata;

   `include "tb_cpu_model.svh"

   cpu u_cpu (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "watchdog expired");
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic pulse_reset();
      @(negedge clk);
      reset = 1'b1;
      repeat (3) @(negedge clk);
      reset = 1'b0;
   endtask

   // one word per cycle while the pipeline is frozen
   task automatic load_program();
      int i;
      for (i = 0; i < prog_len; i++) begin
         @(negedge clk);
         imem_wen   = 1'b1;
         imem_addr  = 64'(4 * i);
         imem_wdata = prog[i];
      end
      @(negedge clk);
      imem_wen = 1'b0;
   endtask

   task automatic run_program();
      int enabled_cycles;
      int low_left;
      int spans;
      enabled_cycles = 0;
      low_left       = 0;
      spans          = 0;
      while (enabled_cycles < prog_len * 3 + 20) begin
         @(negedge clk);
         if (low_left > 0) begin
            enable = 1'b0;
            low_left--;
         end else if (spans < 4 && rand_below(24) == 0) begin
            enable   = 1'b0; // start a frozen span
            low_left = rand_below(6);
            spans++;
         end else begin
            enable = 1'b1;
            enabled_cycles++;
         end
      end
      @(negedge clk);
      enable = 1'b0;
   endtask

   task automatic dump_and_compare(input int p);
      int r;
      for (r = 1; r < 32; r++) begin
         @(negedge clk);
         dmem_addr = 64'(8 * (DUMP_BASE + r - 1));
         dmem_ren  = 1'b1;
         @(negedge clk); // rdata registered at the edge between
         dmem_ren = 1'b0;
         check_value($sformatf("dmem_rdata prog %0d x%0d", p, r), dmem_rdata,
                     m_mem[DUMP_BASE + r - 1]);
      end
   endtask

   initial begin
      int p;
      reset      = 1'b1;
      enable     = 1'b0;
      imem_addr  = '0;
      imem_wen   = 1'b0;
      imem_wdata = '0;
      dmem_addr  = '0;
      dmem_ren   = 1'b0;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check_value("dmem_rdata after reset", dmem_rdata, 64'd0);
      for (p = 0; p < NUM_PROGRAMS; p++) begin
         gen_program();
         if (!run_model()) begin
            $display("model did not reach the final jump of program %0d", p);
            $display("STATUS: FAIL");
            $fatal(1, "reference model failed");
         end
         load_program();
         pulse_reset();
         // previous dump leaves a stale read value behind
         check_value($sformatf("dmem_rdata after reset prog %0d", p), dmem_rdata, 64'd0);
         run_program();
         dump_and_compare(p);
      end
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// ==== cpu.sv ====
// five-stage rv64 subset core; enable low freezes every stage, memories load and dump only while frozen
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu (
   input  logic              clk,
   input  logic              reset,
   input  logic              enable,
   input  logic [`XLEN-1:0]  imem_addr,
   input  logic              imem_wen,
   input  logic [`ILEN-1:0]  imem_wdata,
   input  logic [`XLEN-1:0]  dmem_addr,
   input  logic              dmem_ren,
   output logic [`XLEN-1:0]  dmem_rdata
);
   import cpu_pkg::*;

   // fetch <-> decode
   logic [`ILEN-1:0]       instr_id;
   logic [`XLEN-1:0]       pc_id, target_pc;
   logic                   stall, flush;

   // decode -> execute
   logic [`XLEN-1:0]       rs1_val_ex, rs2_val_ex, imm_ex, pc4_ex;
   logic [`REG_ADDR_W-1:0] rs1_ex, rs2_ex, rd_ex;
   logic [2:0]             funct3_ex;
   logic                   funct7b5_ex;
   alu_class_e             alu_class_ex;
   logic                   alu_src_ex, mem_read_ex, mem_write_ex;
   logic                   reg_write_ex, mem_to_reg_ex, is_jal_ex;

   // execute -> result
   logic [`XLEN-1:0]       alu_out_mem, store_data_mem, pc4_mem;
   logic [`REG_ADDR_W-1:0] rd_mem;
   logic                   mem_read_mem, mem_write_mem, reg_write_mem;
   logic                   mem_to_reg_mem, is_jal_mem;

   // write-back, back to decode and execute
   logic                   wb_wen;
   logic [`REG_ADDR_W-1:0] wb_rd;
   logic [`XLEN-1:0]       wb_data;

   fetch_stage u_fetch (.*);

   decode_stage u_decode (
      .*,
      .rd_ex_out       (rd_ex),
      .mem_read_ex_out (mem_read_ex)
   );

   execute_stage u_execute (.*);

   result_stage u_result (.*);

endmodule

// ==== result_stage.sv ====
// 128-doubleword data memory without reset; external read is registered, one cycle latency
`timescale 1ns/1ps
`include "cpu_defines.svh"

module result_stage (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  enable,
   input  logic [`XLEN-1:0]      alu_out_mem,
   input  logic [`XLEN-1:0]      store_data_mem,
   input  logic [`XLEN-1:0]      pc4_mem,
   input  logic [`REG_ADDR_W-1:0] rd_mem,
   input  logic                  mem_read_mem,
   input  logic                  mem_write_mem,
   input  logic                  reg_write_mem,
   input  logic                  mem_to_reg_mem,
   input  logic                  is_jal_mem,
   input  logic [`XLEN-1:0]      dmem_addr,
   input  logic                  dmem_ren,
   output logic [`XLEN-1:0]      dmem_rdata,
   output logic                  wb_wen,
   output logic [`REG_ADDR_W-1:0] wb_rd,
   output logic [`XLEN-1:0]      wb_data
);

   logic [`XLEN-1:0] dmem [0:`DMEM_DEPTH-1];
   logic [`XLEN-1:0] load_data, load_data_wb, alu_out_wb, pc4_wb;
   logic             mem_to_reg_wb, is_jal_wb;

   assign load_data = mem_read_mem ? dmem[alu_out_mem[`DMEM_ADDR_W+2:3]] : '0;

   always_ff @(posedge clk) begin
      if (enable && mem_write_mem) begin
         dmem[alu_out_mem[`DMEM_ADDR_W+2:3]] <= store_data_mem;
      end
   end

   // external read port, works with the pipeline frozen
   always_ff @(posedge clk) begin
      if (reset)
         dmem_rdata <= '0;
      else if (dmem_ren)
         dmem_rdata <= dmem[dmem_addr[`DMEM_ADDR_W+2:3]];
   end

   // memory/write-back register
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_wen        <= 1'b0;
         mem_to_reg_wb <= 1'b0;
         is_jal_wb     <= 1'b0;
      end else if (enable) begin
         wb_wen        <= reg_write_mem;
         mem_to_reg_wb <= mem_to_reg_mem;
         is_jal_wb     <= is_jal_mem;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         load_data_wb <= load_data;
         alu_out_wb   <= alu_out_mem;
         pc4_wb       <= pc4_mem;
         wb_rd        <= rd_mem;
      end
   end

   assign wb_data = is_jal_wb ? pc4_wb : mem_to_reg_wb ? load_data_wb : alu_out_wb;

endmodule

// ==== execute_stage.sv ====
// forwarding from mem and wb stages; loads are not forwarded from mem, decode stalls them one cycle
`timescale 1ns/1ps
`include "cpu_defines.svh"

module execute_stage (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  enable,
   input  logic [`XLEN-1:0]      rs1_val_ex,
   input  logic [`XLEN-1:0]      rs2_val_ex,
   input  logic [`XLEN-1:0]      imm_ex,
   input  logic [`XLEN-1:0]      pc4_ex,
   input  logic [`REG_ADDR_W-1:0] rs1_ex,
   input  logic [`REG_ADDR_W-1:0] rs2_ex,
   input  logic [`REG_ADDR_W-1:0] rd_ex,
   input  logic [2:0]            funct3_ex,
   input  logic                  funct7b5_ex,
   input  cpu_pkg::alu_class_e   alu_class_ex,
   input  logic                  alu_src_ex,
   input  logic                  mem_read_ex,
   input  logic                  mem_write_ex,
   input  logic                  reg_write_ex,
   input  logic                  mem_to_reg_ex,
   input  logic                  is_jal_ex,
   input  logic                  wb_wen,
   input  logic [`REG_ADDR_W-1:0] wb_rd,
   input  logic [`XLEN-1:0]      wb_data,
   output logic [`XLEN-1:0]      alu_out_mem,
   output logic [`XLEN-1:0]      store_data_mem,
   output logic [`XLEN-1:0]      pc4_mem,
   output logic [`REG_ADDR_W-1:0] rd_mem,
   output logic                  mem_read_mem,
   output logic                  mem_write_mem,
   output logic                  reg_write_mem,
   output logic                  mem_to_reg_mem,
   output logic                  is_jal_mem
);
   import cpu_pkg::*;

   logic [`XLEN-1:0] op_a, fwd_b, op_b, alu_res;
   alu_op_e          alu_op;

   // mem stage first, then wb, then the decoded value
   always_comb begin
      if (reg_write_mem && rd_mem != '0 && rd_mem == rs1_ex)
         op_a = alu_out_mem;
      else if (wb_wen && wb_rd != '0 && wb_rd == rs1_ex)
         op_a = wb_data;
      else
         op_a = rs1_val_ex;

      if (reg_write_mem && rd_mem != '0 && rd_mem == rs2_ex)
         fwd_b = alu_out_mem;
      else if (wb_wen && wb_rd != '0 && wb_rd == rs2_ex)
         fwd_b = wb_data;
      else
         fwd_b = rs2_val_ex;
   end

   assign op_b = alu_src_ex ? imm_ex : fwd_b;

   // alu control
   always_comb begin
      alu_op = ADD;
      if (alu_class_ex != ADD_ONLY) begin
         case (funct3_ex)
            3'b000:  alu_op = (alu_class_ex == REG_OP && funct7b5_ex) ? SUB : ADD;
            3'b010:  alu_op = SLT;
            3'b110:  alu_op = OR;
            3'b111:  alu_op = AND;
            default: alu_op = ADD;
         endcase
      end
   end

   always_comb begin
      case (alu_op)
         SUB:     alu_res = op_a - op_b;
         AND:     alu_res = op_a & op_b;
         OR:      alu_res = op_a | op_b;
         SLT:     alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         default: alu_res = op_a + op_b;
      endcase
   end

   // execute/memory register
   always_ff @(posedge clk) begin
      if (reset) begin
         mem_read_mem   <= 1'b0;
         mem_write_mem  <= 1'b0;
         reg_write_mem  <= 1'b0;
         mem_to_reg_mem <= 1'b0;
         is_jal_mem     <= 1'b0;
      end else if (enable) begin
         mem_read_mem   <= mem_read_ex;
         mem_write_mem  <= mem_write_ex;
         reg_write_mem  <= reg_write_ex;
         mem_to_reg_mem <= mem_to_reg_ex;
         is_jal_mem     <= is_jal_ex;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         alu_out_mem    <= alu_res;
         store_data_mem <= fwd_b; // forwarded rs2
         pc4_mem        <= pc4_ex;
         rd_mem         <= rd_ex;
      end
   end

endmodule

// ==== decode_stage.sv ====
// decode with write-through regfile; beq compares unforwarded values, so sources must be written 3+ instrs earlier
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decode_stage (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  enable,
   input  logic [`ILEN-1:0]      instr_id,
   input  logic [`XLEN-1:0]      pc_id,
   input  logic                  wb_wen,
   input  logic [`REG_ADDR_W-1:0] wb_rd,
   input  logic [`XLEN-1:0]      wb_data,
   input  logic [`REG_ADDR_W-1:0] rd_ex,
   input  logic                  mem_read_ex,
   output logic                  stall,
   output logic                  flush,
   output logic [`XLEN-1:0]      target_pc,
   output logic [`XLEN-1:0]      rs1_val_ex,
   output logic [`XLEN-1:0]      rs2_val_ex,
   output logic [`XLEN-1:0]      imm_ex,
   output logic [`XLEN-1:0]      pc4_ex,
   output logic [`REG_ADDR_W-1:0] rs1_ex,
   output logic [`REG_ADDR_W-1:0] rs2_ex,
   output logic [`REG_ADDR_W-1:0] rd_ex_out,
   output logic [2:0]            funct3_ex,
   output logic                  funct7b5_ex,
   output cpu_pkg::alu_class_e   alu_class_ex,
   output logic                  alu_src_ex,
   output logic                  mem_read_ex_out,
   output logic                  mem_write_ex,
   output logic                  reg_write_ex,
   output logic                  mem_to_reg_ex,
   output logic                  is_jal_ex
);
   import cpu_pkg::*;

   logic [`XLEN-1:0]      regs [1:31]; // x0 is not stored
   opcode_e               opcode;
   alu_class_e            alu_class;
   logic [`REG_ADDR_W-1:0] rs1, rs2;
   logic [`XLEN-1:0]      rs1_val, rs2_val, imm;
   logic                  alu_src, mem_read, mem_write, reg_write, mem_to_reg, is_jal, is_beq;

   assign opcode = opcode_e'(instr_id[`F_OPCODE]);
   assign rs1    = instr_id[`F_RS1];
   assign rs2    = instr_id[`F_RS2];

   always_comb begin
      alu_src    = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      reg_write  = 1'b0;
      mem_to_reg = 1'b0;
      is_jal     = 1'b0;
      is_beq     = 1'b0;
      alu_class  = ADD_ONLY;
      case (opcode)
         OP: begin
            reg_write = 1'b1;
            alu_class = REG_OP;
         end
         OP_IMM: begin
            reg_write = 1'b1;
            alu_src   = 1'b1;
            alu_class = IMM_OP;
         end
         LOAD: begin
            reg_write  = 1'b1;
            alu_src    = 1'b1;
            mem_read   = 1'b1;
            mem_to_reg = 1'b1;
         end
         STORE: begin
            alu_src   = 1'b1;
            mem_write = 1'b1;
         end
         BRANCH: is_beq = 1'b1;
         JAL: begin
            reg_write = 1'b1;
            is_jal    = 1'b1;
         end
         default: ; // all-zero word and unknown opcodes are bubbles
      endcase
   end

   // immediate by format
   always_comb begin
      case (opcode)
         STORE:   imm = {{(`XLEN-12){instr_id[31]}}, instr_id[31:25], instr_id[11:7]};
         BRANCH:  imm = {{(`XLEN-13){instr_id[31]}}, instr_id[31], instr_id[7],
                         instr_id[30:25], instr_id[11:8], 1'b0};
         JAL:     imm = {{(`XLEN-21){instr_id[31]}}, instr_id[31], instr_id[19:12],
                         instr_id[20], instr_id[30:21], 1'b0};
         default: imm = {{(`XLEN-12){instr_id[31]}}, instr_id[31:20]};
      endcase
   end

   // register file, written in wb and read through in the same cycle
   always_ff @(posedge clk) begin
      if (wb_wen && wb_rd != '0) begin
         regs[wb_rd] <= wb_data;
      end
   end

   assign rs1_val = (rs1 == '0) ? '0 : (wb_wen && wb_rd == rs1) ? wb_data : regs[rs1];
   assign rs2_val = (rs2 == '0) ? '0 : (wb_wen && wb_rd == rs2) ? wb_data : regs[rs2];

   // load-use hazard, stall wins over a redirect
   assign stall     = mem_read_ex && rd_ex != '0 && (rd_ex == rs1 || rd_ex == rs2);
   assign flush     = !stall && (is_jal || (is_beq && rs1_val == rs2_val));
   assign target_pc = pc_id + imm;

   // decode/execute controls, zeroed on stall
   always_ff @(posedge clk) begin
      if (reset) begin
         alu_class_ex    <= ADD_ONLY;
         alu_src_ex      <= 1'b0;
         mem_read_ex_out <= 1'b0;
         mem_write_ex    <= 1'b0;
         reg_write_ex    <= 1'b0;
         mem_to_reg_ex   <= 1'b0;
         is_jal_ex       <= 1'b0;
      end else if (enable) begin
         alu_class_ex    <= stall ? ADD_ONLY : alu_class;
         alu_src_ex      <= alu_src && !stall;
         mem_read_ex_out <= mem_read && !stall;
         mem_write_ex    <= mem_write && !stall;
         reg_write_ex    <= reg_write && !stall;
         mem_to_reg_ex   <= mem_to_reg && !stall;
         is_jal_ex       <= is_jal && !stall;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         rs1_val_ex  <= rs1_val;
         rs2_val_ex  <= rs2_val;
         imm_ex      <= imm;
         pc4_ex      <= pc_id + `XLEN'd4; // jal link value
         rs1_ex      <= rs1;
         rs2_ex      <= rs2;
         rd_ex_out   <= instr_id[`F_RD];
         funct3_ex   <= instr_id[`F_FUNCT3];
         funct7b5_ex <= instr_id[`F_FUNCT7B5];
      end
   end

endmodule

// ==== fetch_stage.sv ====
// pc and 128-word instruction memory; imem is loaded only through the external port and has no reset
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetch_stage (
   input  logic              clk,
   input  logic              reset,
   input  logic              enable,
   input  logic              stall,
   input  logic              flush,
   input  logic [`XLEN-1:0]  target_pc,
   input  logic [`XLEN-1:0]  imem_addr,
   input  logic              imem_wen,
   input  logic [`ILEN-1:0]  imem_wdata,
   output logic [`ILEN-1:0]  instr_id,
   output logic [`XLEN-1:0]  pc_id
);

   logic [`ILEN-1:0] imem [0:`IMEM_DEPTH-1];
   logic [`XLEN-1:0] pc;
   logic [`ILEN-1:0] instr_if;

   assign instr_if = imem[pc[`IMEM_ADDR_W+1:2]]; // combinational read

   // external load port
   always_ff @(posedge clk) begin
      if (imem_wen) begin
         imem[imem_addr[`IMEM_ADDR_W+1:2]] <= imem_wdata;
      end
   end

   // pc and fetch/decode instruction
   always_ff @(posedge clk) begin
      if (reset) begin
         pc       <= '0;
         instr_id <= '0;
      end else if (enable) begin
         if (flush) begin
            pc       <= target_pc;
            instr_id <= '0; // wrong path becomes a bubble
         end else if (!stall) begin
            pc       <= pc + `XLEN'd4;
            instr_id <= instr_if;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (enable && !stall) begin
         pc_id <= pc;
      end
   end

endmodule

// ==== cpu_pkg.sv ====
// encodings for the supported rv64 subset only; any other opcode decodes as a bubble
package cpu_pkg;

   // major opcodes that are decoded
   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      BRANCH = 7'b1100011,
      JAL    = 7'b1101111
   } opcode_e;

   // how execute interprets funct bits
   typedef enum logic [1:0] {
      ADD_ONLY = 2'b00, // loads, stores, jal
      REG_OP   = 2'b10,
      IMM_OP   = 2'b11
   } alu_class_e;

   typedef enum logic [2:0] {
      ADD = 3'd0,
      SUB = 3'd1,
      AND = 3'd2,
      OR  = 3'd3,
      SLT = 3'd4  // signed compare
   } alu_op_e;

endpackage

// ==== cpu_defines.svh ====
// sizes and instruction field slices for the rv64 pipeline; memories are 128 entries, not parameterized per instance
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath widths
`define XLEN        64
`define ILEN        32
`define REG_ADDR_W  5

// instruction memory, word index from pc[8:2]
`define IMEM_ADDR_W 7
`define IMEM_DEPTH  128

// data memory, doubleword index from addr[9:3]
`define DMEM_ADDR_W 7
`define DMEM_DEPTH  128

// instruction fields
`define F_OPCODE    6:0
`define F_RD        11:7
`define F_FUNCT3    14:12
`define F_RS1       19:15
`define F_RS2       24:20
`define F_FUNCT7B5  30

`endif
